// File: design/dfp_pkg.sv
// dataflow pipeline package
// token width default and the select and route encodings

package dfp_pkg;

	// ------------------------------------------------------------------------
	// token width
	// ------------------------------------------------------------------------

	// default payload width for every stage
	localparam int data_w_default = 32;

	// ------------------------------------------------------------------------
	// control token encodings
	// ------------------------------------------------------------------------

	// which data input the mux takes
	typedef enum logic {
		sel_in0 = 1'b0,
		sel_in1 = 1'b1
	} sel_e;

	// which output the branch drives
	typedef enum logic {
		route_f = 1'b0,
		route_t = 1'b1
	} route_e;

endpackage

// File: design/tehb_slot.sv
// transparent elastic slot
// passes tokens through with no latency, parks one token while downstream stalls

`timescale 1ns/1ps

module tehb_slot #(
	parameter int data_w = dfp_pkg::data_w_default
) (
	input  logic              clk,
	input  logic              rst,

	input  logic [data_w-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,

	output logic [data_w-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	logic              full;
	logic [data_w-1:0] hold_data;
	logic              capture;

	// parked token has priority over the bypass path
	assign out_valid = in_valid | full;
	assign out_data  = full ? hold_data : in_data;

	// ready comes straight from a flop, so no comb path back upstream
	assign in_ready = ~full;

	// catch the incoming token when it cannot go straight through
	assign capture = in_valid & ~full & ~out_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else begin
			// stays full until the parked token is taken
			full <= out_valid & ~out_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			hold_data <= in_data;
		end
	end

endmodule

// File: design/oehb_slot.sv
// opaque elastic slot
// registers every accepted token, one cycle latency at full throughput

`timescale 1ns/1ps

module oehb_slot #(
	parameter int data_w = dfp_pkg::data_w_default
) (
	input  logic              clk,
	input  logic              rst,

	input  logic [data_w-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,

	output logic [data_w-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	logic              valid_q;
	logic [data_w-1:0] data_q;
	logic              load;

	// empty, or the held token leaves this cycle
	assign in_ready = ~valid_q | out_ready;
	assign load     = in_valid & in_ready;

	assign out_valid = valid_q;
	assign out_data  = data_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			// new token arrives, or the old one is still stuck
			valid_q <= in_valid | ~in_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			data_q <= in_data;
		end
	end

endmodule

// File: design/mux_stage.sv
// select mux stage
// joins a select token with the data input it names, result goes into a tehb slot

`timescale 1ns/1ps

module mux_stage #(
	parameter int data_w = dfp_pkg::data_w_default
) (
	input  logic              clk,
	input  logic              rst,

	input  logic [data_w-1:0] in0_data,
	input  logic              in0_valid,
	output logic              in0_ready,

	input  logic [data_w-1:0] in1_data,
	input  logic              in1_valid,
	output logic              in1_ready,

	input  dfp_pkg::sel_e     sel_data,
	input  logic              sel_valid,
	output logic              sel_ready,

	output logic [data_w-1:0] out_data,
	output logic              out_valid,
	input  logic              out_ready
);

	import dfp_pkg::*;

	logic [data_w-1:0] mux_data;
	logic              mux_valid;
	logic              mux_ready;
	logic              pick_in1;
	logic              chosen_valid;
	logic              take;

	// ------------------------------------------------------------------------
	// join of select and chosen input
	// ------------------------------------------------------------------------

	assign pick_in1     = (sel_data == sel_in1);
	assign chosen_valid = pick_in1 ? in1_valid : in0_valid;

	assign mux_valid = sel_valid & chosen_valid;
	assign mux_data  = pick_in1 ? in1_data : in0_data;

	// both tokens move together, only when the slot takes the result
	assign take = mux_valid & mux_ready;

	// the input that is not named keeps waiting
	assign sel_ready = take;
	assign in0_ready = take & ~pick_in1;
	assign in1_ready = take & pick_in1;

	// ------------------------------------------------------------------------
	// output slot
	// ------------------------------------------------------------------------

	tehb_slot #(
		.data_w(data_w)
	) u_tehb (
		.clk      (clk),
		.rst      (rst),
		.in_data  (mux_data),
		.in_valid (mux_valid),
		.in_ready (mux_ready),
		.out_data (out_data),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// File: design/branch_stage.sv
// branch stage
// joins a data token with a route token and steers it to out_t or out_f

`timescale 1ns/1ps

module branch_stage #(
	parameter int data_w = dfp_pkg::data_w_default
) (
	input  logic              in_valid,
	input  logic [data_w-1:0] in_data,
	output logic              in_ready,

	input  dfp_pkg::route_e   route_data,
	input  logic              route_valid,
	output logic              route_ready,

	output logic [data_w-1:0] out_t_data,
	output logic              out_t_valid,
	input  logic              out_t_ready,

	output logic [data_w-1:0] out_f_data,
	output logic              out_f_valid,
	input  logic              out_f_ready
);

	import dfp_pkg::*;

	logic go_t;
	logic join_valid;
	logic join_ready;
	logic fire;

	// ------------------------------------------------------------------------
	// join of data and route
	// ------------------------------------------------------------------------

	assign join_valid = in_valid & route_valid;
	assign fire       = join_valid & join_ready;

	// an idle side reports ready, a waiting side only on transfer
	assign in_ready    = ~in_valid | fire;
	assign route_ready = ~route_valid | fire;

	// ------------------------------------------------------------------------
	// steering
	// ------------------------------------------------------------------------

	assign go_t = (route_data == route_t);

	assign out_t_valid = join_valid & go_t;
	assign out_f_valid = join_valid & ~go_t;

	// only the named output can hold the join back
	assign join_ready = go_t ? out_t_ready : out_f_ready;

	// payload goes to both, valid decides who sees it
	assign out_t_data = in_data;
	assign out_f_data = in_data;

endmodule

// File: design/select_branch_top.sv
// select and branch pipeline top
// mux with tehb, then an oehb register, then the route branch

`timescale 1ns/1ps

module select_branch_top #(
	parameter int data_w = dfp_pkg::data_w_default
) (
	input  logic              clk,
	input  logic              rst,

	input  logic [data_w-1:0] in0_data,
	input  logic              in0_valid,
	output logic              in0_ready,

	input  logic [data_w-1:0] in1_data,
	input  logic              in1_valid,
	output logic              in1_ready,

	input  dfp_pkg::sel_e     sel_data,
	input  logic              sel_valid,
	output logic              sel_ready,

	input  dfp_pkg::route_e   route_data,
	input  logic              route_valid,
	output logic              route_ready,

	output logic [data_w-1:0] out_t_data,
	output logic              out_t_valid,
	input  logic              out_t_ready,

	output logic [data_w-1:0] out_f_data,
	output logic              out_f_valid,
	input  logic              out_f_ready
);

	// tehb to oehb
	logic [data_w-1:0] buf_data;
	logic              buf_valid;
	logic              buf_ready;

	// oehb to branch
	logic [data_w-1:0] reg_data;
	logic              reg_valid;
	logic              reg_ready;

	mux_stage #(
		.data_w(data_w)
	) u_mux (
		.clk      (clk),
		.rst      (rst),
		.in0_data (in0_data),
		.in0_valid(in0_valid),
		.in0_ready(in0_ready),
		.in1_data (in1_data),
		.in1_valid(in1_valid),
		.in1_ready(in1_ready),
		.sel_data (sel_data),
		.sel_valid(sel_valid),
		.sel_ready(sel_ready),
		.out_data (buf_data),
		.out_valid(buf_valid),
		.out_ready(buf_ready)
	);

	// breaks the forward path between mux and branch
	oehb_slot #(
		.data_w(data_w)
	) u_oehb (
		.clk      (clk),
		.rst      (rst),
		.in_data  (buf_data),
		.in_valid (buf_valid),
		.in_ready (buf_ready),
		.out_data (reg_data),
		.out_valid(reg_valid),
		.out_ready(reg_ready)
	);

	branch_stage #(
		.data_w(data_w)
	) u_branch (
		.in_valid   (reg_valid),
		.in_data    (reg_data),
		.in_ready   (reg_ready),
		.route_data (route_data),
		.route_valid(route_valid),
		.route_ready(route_ready),
		.out_t_data (out_t_data),
		.out_t_valid(out_t_valid),
		.out_t_ready(out_t_ready),
		.out_f_data (out_f_data),
		.out_f_valid(out_f_valid),
		.out_f_ready(out_f_ready)
	);

endmodule

// File: tests/select_branch_assertions.sv
// handshake checks bound to the pipeline top
// valid holds until transfer, one output at a time, quiet outputs in reset

`timescale 1ns/1ps

module select_branch_assertions #(
	parameter int data_w = dfp_pkg::data_w_default
) (
	input logic              clk,
	input logic              rst,
	input logic [data_w-1:0] in0_data,
	input logic              in0_valid, in0_ready,
	input logic [data_w-1:0] in1_data,
	input logic              in1_valid, in1_ready,
	input dfp_pkg::sel_e     sel_data,
	input logic              sel_valid, sel_ready,
	input dfp_pkg::route_e   route_data,
	input logic              route_valid, route_ready,
	input logic [data_w-1:0] out_t_data,
	input logic              out_t_valid, out_t_ready,
	input logic [data_w-1:0] out_f_data,
	input logic              out_f_valid, out_f_ready
);

	// number of assertion failures so far
	int fail_count = 0;

	// ------------------------------------------------------------------------
	// valid and data hold until the transfer
	// ------------------------------------------------------------------------

	in0_hold: assert property (@(posedge clk) disable iff (rst)
		in0_valid && !in0_ready |=> in0_valid && $stable(in0_data))
		else begin
			$error("in0 token dropped or changed before transfer");
			fail_count++;
		end
	in1_hold: assert property (@(posedge clk) disable iff (rst)
		in1_valid && !in1_ready |=> in1_valid && $stable(in1_data))
		else begin
			$error("in1 token dropped or changed before transfer");
			fail_count++;
		end
	sel_hold: assert property (@(posedge clk) disable iff (rst)
		sel_valid && !sel_ready |=> sel_valid && $stable(sel_data))
		else begin
			$error("sel token dropped or changed before transfer");
			fail_count++;
		end
	route_hold: assert property (@(posedge clk) disable iff (rst)
		route_valid && !route_ready |=> route_valid && $stable(route_data))
		else begin
			$error("route token dropped or changed before transfer");
			fail_count++;
		end
	out_t_hold: assert property (@(posedge clk) disable iff (rst)
		out_t_valid && !out_t_ready |=> out_t_valid && $stable(out_t_data))
		else begin
			$error("out_t token dropped or changed before transfer");
			fail_count++;
		end
	out_f_hold: assert property (@(posedge clk) disable iff (rst)
		out_f_valid && !out_f_ready |=> out_f_valid && $stable(out_f_data))
		else begin
			$error("out_f token dropped or changed before transfer");
			fail_count++;
		end

	// ------------------------------------------------------------------------
	// output exclusivity and reset
	// ------------------------------------------------------------------------

	one_output: assert property (@(posedge clk) disable iff (rst)
		!(out_t_valid && out_f_valid))
		else begin
			$error("out_t and out_f valid together");
			fail_count++;
		end
	reset_quiet: assert property (@(posedge clk)
		rst |-> !out_t_valid && !out_f_valid)
		else begin
			$error("output valid during reset");
			fail_count++;
		end

endmodule

// File: tests/select_branch_tb.sv
// select and branch pipeline testbench
// directed tests against a queue model of the select and route rules

`timescale 1ns/1ps

module select_branch_tb;

	import dfp_pkg::*;

	localparam int data_w       = data_w_default;
	localparam int total_tokens = 59;

	logic              clk;
	logic              rst;
	logic [data_w-1:0] in0_data;
	logic              in0_valid, in0_ready;
	logic [data_w-1:0] in1_data;
	logic              in1_valid, in1_ready;
	sel_e              sel_data;
	logic              sel_valid, sel_ready;
	route_e            route_data;
	logic              route_valid, route_ready;
	logic [data_w-1:0] out_t_data;
	logic              out_t_valid, out_t_ready;
	logic [data_w-1:0] out_f_data;
	logic              out_f_valid, out_f_ready;

	// pending input tokens, head is what the driver presents
	logic [data_w-1:0] in0_q[$];
	logic [data_w-1:0] in1_q[$];
	sel_e              sel_q[$];
	route_e            route_q[$];
	// expected output order
	logic [data_w-1:0] exp_data_q[$];
	route_e            exp_route_q[$];

	// 0 outputs ready, 1 both stalled, 2 random stalls
	int stall_mode = 0;
	int accepted = 0;
	int error_count = 0;
	int checks_done = 0;
	bit in0_fired = 1'b0;
	bit in1_fired = 1'b0;
	bit sel_fired = 1'b0;
	bit route_fired = 1'b0;

	select_branch_top #(
		.data_w(data_w)
	) dut (
		.*
	);

	bind select_branch_top select_branch_assertions #(.data_w(data_w)) u_assertions (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------

	task automatic check_data(input string name, input logic [data_w-1:0] got,
			input logic [data_w-1:0] exp);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_route(input route_e got, input route_e exp);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: output port = %s, expected %s", $time, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks_done++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks_done++;
		if (got != exp) begin
			error_count++;
			$display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// one token leaving the DUT, matched against the model
	task automatic deliver(input logic [data_w-1:0] d, input route_e r);
		if (exp_data_q.size() == 0) begin
			error_count++;
			$display("Unexpected token on %s at %0t with nothing outstanding", r.name(), $time);
		end else begin
			check_data(r == route_t ? "out_t_data" : "out_f_data", d, exp_data_q.pop_front());
			check_route(r, exp_route_q.pop_front());
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------

	function automatic logic [data_w-1:0] rand_data();
		return data_w'($urandom());
	endfunction

	// the mux takes the input named by the select, the branch the port named by the route
	task automatic queue_token(input sel_e s, input route_e r, input logic [data_w-1:0] d);
		if (s == sel_in1)
			in1_q.push_back(d);
		else
			in0_q.push_back(d);
		sel_q.push_back(s);
		route_q.push_back(r);
		exp_data_q.push_back(d);
		exp_route_q.push_back(r);
	endtask

	task automatic wait_drain();
		while (exp_data_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
	endtask

	// input driver, works on the falling edge
	initial begin
		logic [31:0] r;
		in0_data    = '0;
		in0_valid   = 1'b0;
		in1_data    = '0;
		in1_valid   = 1'b0;
		sel_data    = sel_in0;
		sel_valid   = 1'b0;
		route_data  = route_f;
		route_valid = 1'b0;
		out_t_ready = 1'b0;
		out_f_ready = 1'b0;
		forever begin
			@(negedge clk);
			// retire what moved at the last rising edge
			if (in0_fired) void'(in0_q.pop_front());
			if (in1_fired) void'(in1_q.pop_front());
			if (sel_fired) void'(sel_q.pop_front());
			if (route_fired) void'(route_q.pop_front());
			in0_valid = (in0_q.size() != 0);
			if (in0_valid) in0_data = in0_q[0];
			in1_valid = (in1_q.size() != 0);
			if (in1_valid) in1_data = in1_q[0];
			sel_valid = (sel_q.size() != 0);
			if (sel_valid) sel_data = sel_q[0];
			route_valid = (route_q.size() != 0);
			if (route_valid) route_data = route_q[0];
			r = $urandom();
			out_t_ready = (stall_mode == 0) || (stall_mode == 2 && r[1:0] != 2'b00);
			out_f_ready = (stall_mode == 0) || (stall_mode == 2 && r[3:2] != 2'b00);
		end
	end

	// transfer monitor on the rising edge
	initial forever begin
		@(posedge clk);
		in0_fired   = in0_valid & in0_ready;
		in1_fired   = in1_valid & in1_ready;
		sel_fired   = sel_valid & sel_ready;
		route_fired = route_valid & route_ready;
		if (in0_fired || in1_fired) accepted++;
		if (out_t_valid && out_t_ready) deliver(out_t_data, route_t);
		if (out_f_valid && out_f_ready) deliver(out_f_data, route_f);
	end

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------

	task automatic reset_idle_test();
		logic [data_w-1:0] d;
		d = rand_data();
		check_flag("out_t_valid", out_t_valid, 1'b0);
		check_flag("out_f_valid", out_f_valid, 1'b0);
		in0_q.push_back(d);
		repeat (8) @(posedge clk);
		// no select yet, so the token must wait at the input
		check_count("in0 tokens pending", in0_q.size(), 1);
		sel_q.push_back(sel_in0);
		repeat (8) @(posedge clk);
		check_flag("out_t_valid", out_t_valid, 1'b0);
		check_flag("out_f_valid", out_f_valid, 1'b0);
		route_q.push_back(route_t);
		exp_data_q.push_back(d);
		exp_route_q.push_back(route_t);
		wait_drain();
	endtask

	task automatic select_test();
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		a = rand_data();
		b = rand_data();
		in1_q.push_back(b);
		queue_token(sel_in0, route_t, a);
		wait_drain();
		repeat (4) @(posedge clk);
		check_flag("in1_valid", in1_valid, 1'b1);
		check_flag("in1_ready", in1_ready, 1'b0);
		check_count("in1 tokens pending", in1_q.size(), 1);
		sel_q.push_back(sel_in1);
		route_q.push_back(route_f);
		exp_data_q.push_back(b);
		exp_route_q.push_back(route_f);
		wait_drain();
	endtask

	task automatic route_test();
		queue_token(sel_in1, route_t, rand_data());
		queue_token(sel_in0, route_f, rand_data());
		wait_drain();
	endtask

	task automatic backpressure_test();
		int base;
		int i;
		logic [31:0] r;
		stall_mode = 1;
		base = accepted;
		for (i = 0; i < 4; i++) begin
			r = $urandom();
			queue_token(sel_in0, r[0] ? route_t : route_f, rand_data());
		end
		repeat (12) @(posedge clk);
		// one token in the oehb, one parked in the tehb
		check_count("accepted tokens", accepted - base, 2);
		check_flag("in0_ready", in0_ready, 1'b0);
		check_flag("sel_ready", sel_ready, 1'b0);
		stall_mode = 0;
		wait_drain();
	endtask

	task automatic stream_test();
		int i;
		logic [31:0] r;
		stall_mode = 2;
		for (i = 0; i < 50; i++) begin
			r = $urandom();
			queue_token(r[0] ? sel_in1 : sel_in0, r[1] ? route_t : route_f, rand_data());
		end
		wait_drain();
		stall_mode = 0;
	endtask

	// watchdog sized from the token count
	initial begin
		repeat (total_tokens * 20 + 200) @(posedge clk);
		$display("Timeout: the pipeline did not deliver all tokens in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hfea5a32f));
		rst = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		reset_idle_test();
		select_test();
		route_test();
		backpressure_test();
		stream_test();
		if (in0_q.size() + in1_q.size() + sel_q.size() + route_q.size() != 0) begin
			error_count++;
			$display("Input tokens were left unconsumed at the end of the run");
		end
		// bound handshake checks count toward the result
		error_count += dut.u_assertions.fail_count;
		$display("checks: %0d, assertion failures: %0d, errors: %0d",
			checks_done, dut.u_assertions.fail_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: filelist.f
design/dfp_pkg.sv
design/tehb_slot.sv
design/oehb_slot.sv
design/mux_stage.sv
design/branch_stage.sv
design/select_branch_top.sv
tests/select_branch_assertions.sv
tests/select_branch_tb.sv

// File: Makefile
# Verilator build and run for the select and branch pipeline

TOP = select_branch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
